// File: common/u1plus_consts.svh
`ifndef U1PLUS_CONSTS_SVH
`define U1PLUS_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// settings bus register map

`define SR_TIME64        8'd40   // +0 secs, +1 ticks, +2 imm flag
`define SR_REG_TEST32    8'd52

////////////////////////////////////////////////////////////////////////////
// misc slave offsets, low 7 address bits

`define REG_LEDS         7'd0
`define REG_CGEN_CTRL    7'd4
`define REG_CGEN_ST      7'd6    // read only
`define REG_TEST         7'd8
`define REG_XFER_RATE    7'd14
`define REG_COMPAT       7'd16   // read only

`define COMPAT_NUM       8'd3
`define MISC_DEFAULT_RD  16'hBEEF

// sync_b and ref_sel both high out of reset
`define CGEN_CTRL_RESET  16'd3

////////////////////////////////////////////////////////////////////////////
// slave decode on adr[15:12]

`define SLV_MISC          4'h0
`define SLV_RDBK          4'h7
`define SLV_SETTINGS      4'h8
`define SLV_SETTINGS_MASK 4'hE   // covers 8 and 9

////////////////////////////////////////////////////////////////////////////
// timekeeper

`define TICKS_PER_SEC    32'd64000000

`endif

// File: common/u1plus_pkg.sv
package u1plus_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // wishbone side, 16-bit host bus

   typedef logic [15:0] wb_adr_t;   // byte address, bits 15..12 pick the slave
   typedef logic [15:0] wb_dat_t;

   ////////////////////////////////////////////////////////////////////////////
   // settings bus

   typedef logic [7:0]  set_addr_t; // one of 256 word registers
   typedef logic [31:0] set_data_t;

   ////////////////////////////////////////////////////////////////////////////
   // vita time

   // seconds in [63:32], ticks in [31:0]
   typedef logic [63:0] vita_time_t;

endpackage

// File: hw/wb_decoder.sv
`include "u1plus_consts.svh"

module wb_decoder
(
   // master side
   input  u1plus_pkg::wb_adr_t m_adr_i,
   input  u1plus_pkg::wb_dat_t m_dat_i,
   output u1plus_pkg::wb_dat_t m_dat_o,
   input  logic                m_we_i,
   input  logic                m_cyc_i,
   input  logic                m_stb_i,
   output logic                m_ack_o,
   // slave 0, misc
   output logic                s0_stb_o,
   input  logic                s0_ack_i,
   input  u1plus_pkg::wb_dat_t s0_dat_i,
   // slave 7, readback
   output logic                s7_stb_o,
   input  logic                s7_ack_i,
   input  u1plus_pkg::wb_dat_t s7_dat_i,
   // slaves 8 and 9, settings
   output logic                s8_stb_o,
   input  logic                s8_ack_i,
   input  u1plus_pkg::wb_dat_t s8_dat_i,
   // shared to all slaves
   output u1plus_pkg::wb_adr_t adr_o,
   output u1plus_pkg::wb_dat_t dat_o,
   output logic                we_o
);

   logic [3:0] code;
   logic       sel0, sel7, sel8;
   logic       req;

   assign code = m_adr_i[15:12];
   assign req  = m_cyc_i & m_stb_i;

   assign sel0 = (code == `SLV_MISC);
   assign sel7 = (code == `SLV_RDBK);
   assign sel8 = ((code & `SLV_SETTINGS_MASK) == (`SLV_SETTINGS & `SLV_SETTINGS_MASK));

   // stb already qualified by cyc
   assign s0_stb_o = req & sel0;
   assign s7_stb_o = req & sel7;
   assign s8_stb_o = req & sel8;

   assign adr_o = m_adr_i;
   assign dat_o = m_dat_i;
   assign we_o  = m_we_i;

   // return path, unmapped codes give no ack and zero data
   always_comb
   begin
      if (sel0)
      begin
         m_ack_o = s0_ack_i;
         m_dat_o = s0_dat_i;
      end
      else if (sel7)
      begin
         m_ack_o = s7_ack_i;
         m_dat_o = s7_dat_i;
      end
      else if (sel8)
      begin
         m_ack_o = s8_ack_i;
         m_dat_o = s8_dat_i;
      end
      else
      begin
         m_ack_o = 1'b0;
         m_dat_o = 16'h0000;
      end
   end

endmodule

// File: hw/misc_regs.sv
`include "u1plus_consts.svh"

module misc_regs
(
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  logic                stb_i,
   input  logic                we_i,
   input  u1plus_pkg::wb_adr_t adr_i,
   input  u1plus_pkg::wb_dat_t dat_i,
   output u1plus_pkg::wb_dat_t dat_o,
   output logic                ack_o,
   input  logic                cgen_st_status_i,
   input  logic                cgen_st_ld_i,
   input  logic                cgen_st_refmon_i,
   output logic [2:0]          debug_led_o,
   output logic                cgen_sync_b_o,
   output logic                cgen_ref_sel_o
);

   import u1plus_pkg::*;

   wb_dat_t    reg_leds, reg_cgen_ctrl, reg_test, reg_xfer_rate;
   logic [6:0] offs;

   assign offs  = adr_i[6:0];
   assign ack_o = stb_i;   // zero wait state

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= `CGEN_CTRL_RESET;
         reg_test      <= '0;
         reg_xfer_rate <= '0;
      end
      else if (stb_i & we_i)
      begin
         case (offs)
            `REG_LEDS      : reg_leds      <= dat_i;
            `REG_CGEN_CTRL : reg_cgen_ctrl <= dat_i;
            `REG_TEST      : reg_test      <= dat_i;
            `REG_XFER_RATE : reg_xfer_rate <= dat_i;
            default        : ;   // read only or unused
         endcase
      end
   end

   // board wires leds 0 and 1 swapped
   assign debug_led_o    = {reg_leds[2], reg_leds[0], reg_leds[1]};
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

   always_comb
   begin
      case (offs)
         `REG_LEDS      : dat_o = reg_leds;
         `REG_CGEN_CTRL : dat_o = reg_cgen_ctrl;
         `REG_CGEN_ST   : dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         `REG_TEST      : dat_o = reg_test;
         `REG_XFER_RATE : dat_o = reg_xfer_rate;
         `REG_COMPAT    : dat_o = {8'd0, `COMPAT_NUM};
         default        : dat_o = `MISC_DEFAULT_RD;
      endcase
   end

endmodule

// File: hw/readback_mux_16le.sv
module readback_mux_16le
(
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic                  stb_i,
   input  u1plus_pkg::wb_adr_t   adr_i,
   output u1plus_pkg::wb_dat_t   dat_o,
   output logic                  ack_o,
   input  u1plus_pkg::set_data_t word00_i, word01_i, word02_i, word03_i,
   input  u1plus_pkg::set_data_t word04_i, word05_i, word06_i, word07_i,
   input  u1plus_pkg::set_data_t word08_i, word09_i, word10_i, word11_i,
   input  u1plus_pkg::set_data_t word12_i, word13_i, word14_i, word15_i
);

   import u1plus_pkg::*;

   set_data_t words [16];
   set_data_t sel_word;
   logic      stb_q;
   logic      stb_rise;

   assign words[0]  = word00_i;
   assign words[1]  = word01_i;
   assign words[2]  = word02_i;
   assign words[3]  = word03_i;
   assign words[4]  = word04_i;
   assign words[5]  = word05_i;
   assign words[6]  = word06_i;
   assign words[7]  = word07_i;
   assign words[8]  = word08_i;
   assign words[9]  = word09_i;
   assign words[10] = word10_i;
   assign words[11] = word11_i;
   assign words[12] = word12_i;
   assign words[13] = word13_i;
   assign words[14] = word14_i;
   assign words[15] = word15_i;

   assign sel_word = words[adr_i[5:2]];
   assign stb_rise = stb_i & ~stb_q;   // one ack per strobe

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         ack_o <= 1'b0;
         stb_q <= 1'b0;
      end
      else
      begin
         ack_o <= stb_rise;
         stb_q <= stb_i;
      end
   end

   // bit 1 picks the upper half
   always_ff @(posedge wb_clk)
   begin
      if (stb_rise)
         dat_o <= adr_i[1] ? sel_word[31:16] : sel_word[15:0];
   end

endmodule

// File: hw/settings/settings_bus_16le.sv
module settings_bus_16le
(
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  u1plus_pkg::wb_adr_t   adr_i,
   input  u1plus_pkg::wb_dat_t   dat_i,
   output logic                  ack_o,
   output logic                  set_stb_o,
   output u1plus_pkg::set_addr_t set_addr_o,
   output u1plus_pkg::set_data_t set_data_o
);

   import u1plus_pkg::*;

   wb_dat_t low_q;      // low half, waits for the high write
   logic    stb_q;
   logic    stb_rise;

   assign stb_rise = stb_i & ~stb_q;

   ////////////////////////////////////////////////////////////////////////////
   // handshake and strobe

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         ack_o     <= 1'b0;
         stb_q     <= 1'b0;
         set_stb_o <= 1'b0;
      end
      else
      begin
         ack_o     <= stb_rise;
         stb_q     <= stb_i;
         set_stb_o <= stb_rise & we_i & adr_i[1];   // high half completes the word
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // payload

   always_ff @(posedge wb_clk)
   begin
      if (stb_rise & we_i)
      begin
         if (!adr_i[1])
            low_q <= dat_i;
         else
         begin
            set_addr_o <= adr_i[9:2];
            set_data_o <= {dat_i, low_q};
         end
      end
   end

endmodule

// File: hw/settings/setting_reg.sv
module setting_reg
#(
   parameter int               MY_ADDR  = 0,
   parameter int               WIDTH    = 32,
   parameter logic [WIDTH-1:0] AT_RESET = '0
)
(
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic                  set_stb_i,
   input  u1plus_pkg::set_addr_t set_addr_i,
   input  u1plus_pkg::set_data_t set_data_i,
   output logic [WIDTH-1:0]      out_o,
   output logic                  changed_o
);

   import u1plus_pkg::*;

   logic hit;

   assign hit = set_stb_i & (set_addr_i == set_addr_t'(MY_ADDR));

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         out_o     <= AT_RESET;
         changed_o <= 1'b0;
      end
      else
      begin
         if (hit)
            out_o <= set_data_i[WIDTH-1:0];
         changed_o <= hit;   // single pulse per write
      end
   end

endmodule

// File: hw/timekeeper/time_64bit.sv
`include "u1plus_consts.svh"

module time_64bit
#(
   parameter int unsigned TICKS_PER_SEC = `TICKS_PER_SEC,
   parameter int          BASE          = `SR_TIME64
)
(
   input  logic                   wb_clk,
   input  logic                   wb_rst,
   input  logic                   set_stb_i,
   input  u1plus_pkg::set_addr_t  set_addr_i,
   input  u1plus_pkg::set_data_t  set_data_i,
   input  logic                   pps_i,
   output u1plus_pkg::vita_time_t vita_time_o,
   output u1plus_pkg::vita_time_t vita_time_pps_o
);

   import u1plus_pkg::*;

   set_data_t secs_new, ticks_new;
   logic      set_imm;
   logic      ticks_changed;
   set_data_t secs_q, ticks_q;
   logic      pps_s1, pps_s2, pps_s3;
   logic      pps_edge;
   logic      pending;
   logic      load_now;

   ////////////////////////////////////////////////////////////////////////////
   // pending time, written through the settings bus

   setting_reg #(.MY_ADDR(BASE), .WIDTH(32)) sr_secs
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .out_o(secs_new), .changed_o()
   );

   // writing ticks arms the load
   setting_reg #(.MY_ADDR(BASE + 1), .WIDTH(32)) sr_ticks
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .out_o(ticks_new), .changed_o(ticks_changed)
   );

   setting_reg #(.MY_ADDR(BASE + 2), .WIDTH(1)) sr_imm
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .out_o(set_imm), .changed_o()
   );

   ////////////////////////////////////////////////////////////////////////////
   // pps sync and edge detect

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_s1 <= 1'b0;
         pps_s2 <= 1'b0;
         pps_s3 <= 1'b0;
      end
      else
      begin
         pps_s1 <= pps_i;   // async input
         pps_s2 <= pps_s1;
         pps_s3 <= pps_s2;
      end
   end

   assign pps_edge = pps_s2 & ~pps_s3;
   assign load_now = (ticks_changed & set_imm) | (pending & pps_edge);

   ////////////////////////////////////////////////////////////////////////////
   // counter, pending flag and capture

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         secs_q          <= '0;
         ticks_q         <= '0;
         pending         <= 1'b0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         if (load_now)
         begin
            secs_q  <= secs_new;
            ticks_q <= ticks_new;
         end
         else if (ticks_q == set_data_t'(TICKS_PER_SEC - 1))
         begin
            secs_q  <= secs_q + 32'd1;
            ticks_q <= '0;
         end
         else
            ticks_q <= ticks_q + 32'd1;

         if (ticks_changed & ~set_imm)
            pending <= 1'b1;   // wait for next pps
         else if (pps_edge)
            pending <= 1'b0;

         if (pps_edge)
            vita_time_pps_o <= vita_time_o;   // time before any load
      end
   end

   assign vita_time_o = {secs_q, ticks_q};

endmodule

// File: hw/u1plus_ctrl_core.sv
`include "u1plus_consts.svh"

module u1plus_ctrl_core
(
   input  logic                wb_clk,
   input  logic                wb_rst,
   // host wishbone master
   input  u1plus_pkg::wb_adr_t m0_adr_i,
   input  u1plus_pkg::wb_dat_t m0_dat_i,
   output u1plus_pkg::wb_dat_t m0_dat_o,
   input  logic                m0_we_i,
   input  logic                m0_cyc_i,
   input  logic                m0_stb_i,
   output logic                m0_ack_o,
   // board
   output logic [2:0]          debug_led_o,
   output logic                cgen_sync_b_o,
   output logic                cgen_ref_sel_o,
   input  logic                cgen_st_status_i,
   input  logic                cgen_st_ld_i,
   input  logic                cgen_st_refmon_i,
   input  logic                pps_i
);

   import u1plus_pkg::*;

   wb_adr_t    s_adr;
   wb_dat_t    s_dat_mosi;
   logic       s_we;

   logic       s0_stb, s0_ack;
   wb_dat_t    s0_dat_miso;
   logic       s7_stb, s7_ack;
   wb_dat_t    s7_dat_miso;
   logic       s8_stb, s8_ack;

   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;

   set_data_t  reg_test32;
   vita_time_t vita_time, vita_time_pps;

   ////////////////////////////////////////////////////////////////////////////
   // intercon, single master

   wb_decoder i_wb_decoder
   (
      .m_adr_i(m0_adr_i), .m_dat_i(m0_dat_i), .m_dat_o(m0_dat_o),
      .m_we_i(m0_we_i), .m_cyc_i(m0_cyc_i), .m_stb_i(m0_stb_i), .m_ack_o(m0_ack_o),
      .s0_stb_o(s0_stb), .s0_ack_i(s0_ack), .s0_dat_i(s0_dat_miso),
      .s7_stb_o(s7_stb), .s7_ack_i(s7_ack), .s7_dat_i(s7_dat_miso),
      .s8_stb_o(s8_stb), .s8_ack_i(s8_ack), .s8_dat_i(16'h0000),   // write only
      .adr_o(s_adr), .dat_o(s_dat_mosi), .we_o(s_we)
   );

   ////////////////////////////////////////////////////////////////////////////
   // slave 0, misc regs

   misc_regs i_misc_regs
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(s0_stb), .we_i(s_we), .adr_i(s_adr), .dat_i(s_dat_mosi),
      .dat_o(s0_dat_miso), .ack_o(s0_ack),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .debug_led_o(debug_led_o), .cgen_sync_b_o(cgen_sync_b_o),
      .cgen_ref_sel_o(cgen_ref_sel_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // slaves 8 and 9, settings bus and its users

   settings_bus_16le i_settings_bus
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(s8_stb), .we_i(s_we), .adr_i(s_adr), .dat_i(s_dat_mosi), .ack_o(s8_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data)
   );

   setting_reg #(.MY_ADDR(`SR_REG_TEST32), .WIDTH(32), .AT_RESET(32'h0)) sr_reg_test32
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .out_o(reg_test32), .changed_o()
   );

   time_64bit #(.TICKS_PER_SEC(`TICKS_PER_SEC), .BASE(`SR_TIME64)) i_time_64bit
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps)
   );

   ////////////////////////////////////////////////////////////////////////////
   // slave 7, readback

   readback_mux_16le i_readback_mux
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(s7_stb), .adr_i(s_adr), .dat_o(s7_dat_miso), .ack_o(s7_ack),
      .word00_i(vita_time[63:32]),     .word01_i(vita_time[31:0]),
      .word02_i(vita_time_pps[63:32]), .word03_i(vita_time_pps[31:0]),
      .word04_i(reg_test32),           .word05_i(32'h0),
      .word06_i(32'h0),                .word07_i(32'h0),
      .word08_i(32'h0),                .word09_i(32'h0),
      .word10_i(32'h0),                .word11_i(32'h0),
      .word12_i(32'h0),                .word13_i(32'h0),
      .word14_i(32'h0),                .word15_i(32'h0)
   );

endmodule

// File: dv/tb_u1plus_ctrl_core.sv
`include "u1plus_consts.svh"

module tb_u1plus_ctrl_core;

   import u1plus_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int DRIVE_DLY  = 10;
   localparam int NUM_RAND   = 200;
   localparam int NUM_FIXED  = 60;   // upper bound on directed bus cycles

   logic       wb_clk;
   logic       wb_rst;
   wb_adr_t    m0_adr;
   wb_dat_t    m0_dat_mosi;
   wb_dat_t    m0_dat_miso;
   logic       m0_we;
   logic       m0_cyc;
   logic       m0_stb;
   logic       m0_ack;
   logic [2:0] debug_led;
   logic       cgen_sync_b;
   logic       cgen_ref_sel;
   logic       st_status;
   logic       st_ld;
   logic       st_refmon;
   logic       pps;

   integer     seed;
   integer     errors;
   wb_dat_t    mdl_misc [0:127];   // writable misc offsets only
   set_data_t  mdl_test32;

   u1plus_ctrl_core i_dut
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .m0_adr_i(m0_adr), .m0_dat_i(m0_dat_mosi), .m0_dat_o(m0_dat_miso),
      .m0_we_i(m0_we), .m0_cyc_i(m0_cyc), .m0_stb_i(m0_stb), .m0_ack_o(m0_ack),
      .debug_led_o(debug_led), .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel),
      .cgen_st_status_i(st_status), .cgen_st_ld_i(st_ld), .cgen_st_refmon_i(st_refmon),
      .pps_i(pps)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
   end

   initial
   begin
      #((NUM_RAND + NUM_FIXED) * 20 * CLK_PERIOD);
      $display("watchdog expired, a bus cycle never got its ack");
      $display("Simulation FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // compare and bus helpers

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   // drive after the edge and sample ack on the falling edge
   task automatic bus_cycle(input wb_adr_t adr, input logic we, input wb_dat_t wdat,
                            output wb_dat_t rdat);
      @(posedge wb_clk);
      #DRIVE_DLY;
      m0_adr      = adr;
      m0_dat_mosi = wdat;
      m0_we       = we;
      m0_cyc      = 1'b1;
      m0_stb      = 1'b1;
      @(negedge wb_clk);
      while (!m0_ack)
         @(negedge wb_clk);
      rdat = m0_dat_miso;
      @(posedge wb_clk);
      #DRIVE_DLY;
      m0_cyc = 1'b0;
      m0_stb = 1'b0;
      m0_we  = 1'b0;
   endtask

   task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
      wb_dat_t unused;
      bus_cycle(adr, 1'b1, dat, unused);
   endtask

   task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
      bus_cycle(adr, 1'b0, 16'h0000, dat);
   endtask

   // low half first and then the high half that fires the strobe
   task automatic set_write(input set_addr_t addr, input set_data_t data);
      wb_write({4'h8, 2'd0, addr, 1'b0, 1'b0}, data[15:0]);
      wb_write({4'h8, 2'd0, addr, 1'b1, 1'b0}, data[31:16]);
   endtask

   task automatic read_word(input logic [3:0] idx, output set_data_t data);
      wb_dat_t lo;
      wb_dat_t hi;
      wb_read({4'h7, 6'd0, idx, 1'b0, 1'b0}, lo);
      wb_read({4'h7, 6'd0, idx, 1'b1, 1'b0}, hi);
      data = {hi, lo};
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // misc register model

   function automatic logic is_writable(input logic [6:0] offs);
      return (offs == `REG_LEDS) || (offs == `REG_CGEN_CTRL) ||
             (offs == `REG_TEST) || (offs == `REG_XFER_RATE);
   endfunction

   function automatic wb_dat_t misc_expect(input logic [6:0] offs);
      if (is_writable(offs))
         return mdl_misc[offs];
      if (offs == `REG_CGEN_ST)
         return {13'd0, st_status, st_ld, st_refmon};
      if (offs == `REG_COMPAT)
         return 16'd3;
      return 16'hBEEF;   // unmapped offset
   endfunction

   task automatic misc_write(input logic [6:0] offs, input wb_dat_t dat);
      wb_write({9'd0, offs}, dat);
      if (is_writable(offs))
         mdl_misc[offs] = dat;
   endtask

   task automatic misc_check(input logic [6:0] offs, input string name);
      wb_dat_t rd;
      wb_read({9'd0, offs}, rd);
      check(name, misc_expect(offs), rd);
   endtask

   task automatic check_board(input string name);
      logic [2:0] led_exp;
      led_exp[0] = mdl_misc[`REG_LEDS][1];   // board swaps leds 0 and 1
      led_exp[1] = mdl_misc[`REG_LEDS][0];
      led_exp[2] = mdl_misc[`REG_LEDS][2];
      check(name, led_exp, debug_led);
      check(name, mdl_misc[`REG_CGEN_CTRL][1], cgen_sync_b);
      check(name, mdl_misc[`REG_CGEN_CTRL][0], cgen_ref_sel);
   endtask

   task automatic drive_random_inputs(input logic with_pps);
      logic [31:0] r;
      r = $random(seed);
      st_status = r[0];
      st_ld     = r[1];
      st_refmon = r[2];
      if (with_pps)
         pps = r[3];
   endtask

   task automatic pulse_pps();
      @(posedge wb_clk);
      #DRIVE_DLY;
      pps = 1'b1;
      repeat (6) @(posedge wb_clk);   // covers sync and edge latency
      #DRIVE_DLY;
      pps = 1'b0;
   endtask

   function automatic logic [6:0] pick_offset(input logic [2:0] k);
      case (k)
         3'd0    : return `REG_LEDS;
         3'd1    : return `REG_CGEN_CTRL;
         3'd2    : return `REG_CGEN_ST;
         3'd3    : return `REG_TEST;
         3'd4    : return `REG_XFER_RATE;
         3'd5    : return `REG_COMPAT;
         3'd6    : return 7'd2;
         default : return 7'd10;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // test sequence

   initial
   begin : main
      set_data_t   w0;
      set_data_t   tick_a;
      set_data_t   tick_b;
      set_data_t   secs_s;
      set_data_t   secs_s2;
      logic [31:0] op;
      logic [31:0] r;
      logic [6:0]  offs;
      time         t_load;

      seed        = 29230;
      errors      = 0;
      wb_rst      = 1'b1;
      m0_adr      = '0;
      m0_dat_mosi = '0;
      m0_we       = 1'b0;
      m0_cyc      = 1'b0;
      m0_stb      = 1'b0;
      st_status   = 1'b0;
      st_ld       = 1'b0;
      st_refmon   = 1'b0;
      pps         = 1'b0;
      for (int i = 0; i < 128; i++)
         mdl_misc[i] = 16'h0000;
      mdl_misc[`REG_CGEN_CTRL] = 16'd3;
      mdl_test32 = '0;

      repeat (8) @(posedge wb_clk);
      #DRIVE_DLY;
      wb_rst = 1'b0;

      // reset values
      misc_check(`REG_LEDS, "reset_leds");
      misc_check(`REG_CGEN_CTRL, "reset_cgen_ctrl");
      misc_check(`REG_TEST, "reset_test");
      misc_check(`REG_XFER_RATE, "reset_xfer_rate");
      misc_check(`REG_COMPAT, "reset_compat");
      misc_check(7'd2, "reset_unused");
      check_board("reset_board");

      // directed misc writes
      misc_write(`REG_LEDS, 16'h0005);
      check_board("leds_101");
      misc_write(`REG_LEDS, 16'h0002);
      check_board("leds_010");
      misc_write(`REG_CGEN_CTRL, 16'h0002);
      check_board("cgen_sync_only");
      misc_write(`REG_CGEN_CTRL, 16'h0001);
      check_board("cgen_ref_only");
      misc_write(`REG_TEST, 16'hA5C3);
      misc_write(`REG_XFER_RATE, 16'h1234);
      misc_check(`REG_LEDS, "rd_leds");
      misc_check(`REG_CGEN_CTRL, "rd_cgen_ctrl");
      misc_check(`REG_TEST, "rd_test");
      misc_check(`REG_XFER_RATE, "rd_xfer_rate");
      repeat (4)
      begin
         drive_random_inputs(1'b0);
         misc_check(`REG_CGEN_ST, "cgen_status");
      end

      // test32 through readback word 4
      mdl_test32 = $random(seed);
      set_write(`SR_REG_TEST32, mdl_test32);
      read_word(4'd4, w0);
      check("test32_rdbk", mdl_test32, w0);

      // immediate time load
      secs_s = $random(seed) & 32'h00FF_FFFF;
      set_write(`SR_TIME64 + 2, 32'd1);
      set_write(`SR_TIME64, secs_s);
      set_write(`SR_TIME64 + 1, 32'd0);
      t_load = $time;
      read_word(4'd0, w0);
      check("imm_secs", secs_s, w0);
      read_word(4'd1, tick_a);
      // ticks loaded as zero stay within the cycles since the write
      check("imm_ticks_range", 1, tick_a <= ($time - t_load) / CLK_PERIOD);
      read_word(4'd1, tick_b);
      check("imm_ticks_grow", 1, tick_b > tick_a);

      // deferred load of the next second at the pps edge
      secs_s2 = secs_s + 32'd1;
      set_write(`SR_TIME64 + 2, 32'd0);
      set_write(`SR_TIME64, secs_s2);
      set_write(`SR_TIME64 + 1, 32'd0);
      read_word(4'd0, w0);
      check("defer_secs_before_pps", 1, w0 != secs_s2);
      pulse_pps();
      read_word(4'd0, w0);
      check("defer_secs_after_pps", secs_s2, w0);
      read_word(4'd2, tick_a);   // captured secs
      read_word(4'd3, tick_b);   // captured ticks
      check("pps_cap_secs", 1, (tick_a == secs_s2) || (tick_a == secs_s2 - 32'd1));
      check("pps_cap_ticks", 1, (tick_b != 0) && (tick_b < `TICKS_PER_SEC));

      // random mix against the model
      for (int n = 0; n < NUM_RAND; n++)
      begin
         drive_random_inputs(1'b1);
         op   = $random(seed);
         r    = $random(seed);
         offs = pick_offset(op[6:4]);
         case (op[1:0])
            2'd0 :
            begin
               misc_write(offs, r[15:0]);
               check_board("rand_board");
            end
            2'd1 : misc_check(offs, "rand_misc_read");
            2'd2 :
            begin
               set_write(`SR_REG_TEST32, r);
               mdl_test32 = r;
            end
            default :
            begin
               read_word(4'd4, w0);
               check("rand_test32", mdl_test32, w0);
            end
         endcase
      end

      $display("run complete, errors: %0d", errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: u1plus_ctrl_core.f
+incdir+common
common/u1plus_pkg.sv
hw/wb_decoder.sv
hw/misc_regs.sv
hw/readback_mux_16le.sv
hw/settings/settings_bus_16le.sv
hw/settings/setting_reg.sv
hw/timekeeper/time_64bit.sv
hw/u1plus_ctrl_core.sv
dv/tb_u1plus_ctrl_core.sv
